// File: source/dvbs2_defs.svh
`ifndef DVBS2_DEFS_SVH
`define DVBS2_DEFS_SVH

// transport packet length in bytes, sync byte included
`define DVB_PKT_BYTES 188
`define DVB_SYNC_BYTE 8'h47

// packets per scrambling frame
`define DVB_FRAME_PKTS 2

// x^8+x^7+x^6+x^4+x^2+1
`define DVB_CRC_POLY 8'hD5

// stage 1 on the left, stage 15 on the right
`define DVB_PRBS_SEED 15'b100101010000000

// 0.7071 in Q1.13
`define DVB_QPSK_AMP 16'h16A0

`endif

// File: source/dvbs2_pkg.sv
package dvbs2_pkg;

	// stream byte and crc register
	typedef logic [7:0] byte_t;
	typedef logic [7:0] crc_t;

	// scrambler state, bit 14 is stage 1
	typedef logic [14:0] prbs_t;

	// one I or Q component, Q1.13
	typedef logic signed [15:0] sample_t;

	// byte position in a packet, packet index in a frame
	typedef logic [7:0] pkt_cnt_t;
	typedef logic [7:0] frm_cnt_t;

	typedef enum logic {HUNT, IN_PACKET} align_state_t;

	typedef enum logic {EMPTY, EMITTING} map_state_t;

endpackage

// File: source/byte_stream_if.sv
`timescale 1ns/1ps

interface byte_stream_if;

	dvbs2_pkg::byte_t data;
	logic valid;
	logic ready;
	// marks the first byte of a scrambling frame
	logic frame_start;

	modport src (
		output data,
		output valid,
		output frame_start,
		input ready
	);

	modport snk (
		input data,
		input valid,
		input frame_start,
		output ready
	);

endinterface

// File: source/ts_crc_inserter.sv
`timescale 1ns/1ps
`include "dvbs2_defs.svh"

module ts_crc_inserter (
	input logic clk,
	input logic rst_n,
	input dvbs2_pkg::byte_t ts_data,
	input logic ts_valid,
	input logic ts_sync,
	output logic ts_ready,
	byte_stream_if.src out_s
);

	localparam dvbs2_pkg::pkt_cnt_t LAST_POS = dvbs2_pkg::pkt_cnt_t'(`DVB_PKT_BYTES - 1);
	localparam dvbs2_pkg::frm_cnt_t LAST_PKT = dvbs2_pkg::frm_cnt_t'(`DVB_FRAME_PKTS - 1);

	dvbs2_pkg::align_state_t state_q;
	dvbs2_pkg::pkt_cnt_t pos_q;
	dvbs2_pkg::pkt_cnt_t byte_pos;
	dvbs2_pkg::frm_cnt_t frm_q;
	dvbs2_pkg::crc_t crc_q;

	dvbs2_pkg::byte_t out_data_q;
	logic out_fs_q;
	logic out_valid_q;

	logic accept;
	logic in_pkt;
	logic pkt_start;

	// one crc step per byte, msb first
	function automatic dvbs2_pkg::crc_t crc8_byte(input dvbs2_pkg::crc_t crc_in,
			input dvbs2_pkg::byte_t din);
		dvbs2_pkg::crc_t c;
		logic fb;
		c = crc_in;
		for (int i = 7; i >= 0; i--) begin
			fb = c[7] ^ din[i];
			c = {c[6:0], 1'b0};
			if (fb) begin
				c = c ^ `DVB_CRC_POLY;
			end
		end
		return c;
	endfunction

	// register stage takes a byte when empty or draining
	assign ts_ready = !out_valid_q || out_s.ready;
	assign accept = ts_valid && ts_ready;

	// a sync flag always restarts the packet at position 0
	assign byte_pos = ts_sync ? '0 : pos_q;
	assign in_pkt = ts_sync || (state_q == dvbs2_pkg::IN_PACKET);
	assign pkt_start = in_pkt && (byte_pos == '0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= dvbs2_pkg::HUNT;
			pos_q <= '0;
			frm_q <= '0;
			crc_q <= '0;
		end else if (accept && in_pkt) begin
			state_q <= dvbs2_pkg::IN_PACKET;
			if (byte_pos == LAST_POS) begin
				pos_q <= '0;
			end else begin
				pos_q <= byte_pos + 1'b1;
			end
			if (pkt_start) begin
				// crc of the finished packet leaves with this byte
				crc_q <= '0;
				if (frm_q == LAST_PKT) begin
					frm_q <= '0;
				end else begin
					frm_q <= frm_q + 1'b1;
				end
			end else begin
				crc_q <= crc8_byte(crc_q, ts_data);
			end
		end
	end

	// hunt bytes are dropped and never reach the output
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid_q <= 1'b0;
		end else if (accept && in_pkt) begin
			out_valid_q <= 1'b1;
		end else if (out_s.ready) begin
			out_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept && in_pkt) begin
			out_data_q <= pkt_start ? crc_q : ts_data;
			out_fs_q <= pkt_start && (frm_q == '0);
		end
	end

	assign out_s.data = out_data_q;
	assign out_s.valid = out_valid_q;
	assign out_s.frame_start = out_fs_q;

endmodule

// File: source/bb_scrambler.sv
`timescale 1ns/1ps
`include "dvbs2_defs.svh"

module bb_scrambler (
	input logic clk,
	input logic rst_n,
	byte_stream_if.snk in_s,
	byte_stream_if.src out_s
);

	dvbs2_pkg::prbs_t prbs_q;
	dvbs2_pkg::prbs_t prbs_nxt;
	dvbs2_pkg::byte_t scr_byte;

	dvbs2_pkg::byte_t out_data_q;
	logic out_fs_q;
	logic out_valid_q;

	logic accept;

	assign in_s.ready = !out_valid_q || out_s.ready;
	assign accept = in_s.valid && in_s.ready;

	// eight prbs steps per byte, msb first
	always_comb begin
		dvbs2_pkg::prbs_t st;
		logic fb;
		// frame start reloads the seed before its own byte
		st = in_s.frame_start ? `DVB_PRBS_SEED : prbs_q;
		scr_byte = '0;
		for (int i = 7; i >= 0; i--) begin
			// stages 14 and 15 are the two oldest bits
			fb = st[1] ^ st[0];
			scr_byte[i] = in_s.data[i] ^ fb;
			st = {fb, st[14:1]};
		end
		prbs_nxt = st;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			prbs_q <= `DVB_PRBS_SEED;
		end else if (accept) begin
			prbs_q <= prbs_nxt;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid_q <= 1'b0;
		end else if (accept) begin
			out_valid_q <= 1'b1;
		end else if (out_s.ready) begin
			out_valid_q <= 1'b0;
		end
	end

	// frame marker rides along with its byte
	always_ff @(posedge clk) begin
		if (accept) begin
			out_data_q <= scr_byte;
			out_fs_q <= in_s.frame_start;
		end
	end

	assign out_s.data = out_data_q;
	assign out_s.valid = out_valid_q;
	assign out_s.frame_start = out_fs_q;

endmodule

// File: source/qpsk_mapper.sv
`timescale 1ns/1ps
`include "dvbs2_defs.svh"

module qpsk_mapper (
	input logic clk,
	input logic rst_n,
	byte_stream_if.snk in_s,
	input logic sym_ready,
	output logic sym_valid,
	output dvbs2_pkg::sample_t sym_re,
	output dvbs2_pkg::sample_t sym_im
);

	localparam dvbs2_pkg::sample_t AMP_POS = `DVB_QPSK_AMP;
	// 16'hE960
	localparam dvbs2_pkg::sample_t AMP_NEG = -AMP_POS;

	dvbs2_pkg::map_state_t state_q;
	dvbs2_pkg::byte_t byte_q;
	logic [1:0] pair_q;

	logic [2:0] bit_i;
	logic [2:0] bit_q;
	logic last_pair;
	logic in_take;
	logic sym_take;

	assign last_pair = (pair_q == 2'd3);
	assign sym_valid = (state_q == dvbs2_pkg::EMITTING);
	assign sym_take = sym_valid && sym_ready;

	// next byte loads as the fourth symbol leaves
	assign in_s.ready = (state_q == dvbs2_pkg::EMPTY) || (last_pair && sym_ready);
	assign in_take = in_s.valid && in_s.ready;

	// pair k is bits 7-2k and 6-2k
	assign bit_i = 3'd7 - {pair_q, 1'b0};
	assign bit_q = 3'd6 - {pair_q, 1'b0};

	// 0 maps to +amp, 1 to -amp
	assign sym_re = byte_q[bit_i] ? AMP_NEG : AMP_POS;
	assign sym_im = byte_q[bit_q] ? AMP_NEG : AMP_POS;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= dvbs2_pkg::EMPTY;
			pair_q <= 2'd0;
		end else if (in_take) begin
			state_q <= dvbs2_pkg::EMITTING;
			pair_q <= 2'd0;
		end else if (sym_take) begin
			// index wraps to 0 after the last pair
			pair_q <= pair_q + 2'd1;
			if (last_pair) begin
				state_q <= dvbs2_pkg::EMPTY;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_take) begin
			byte_q <= in_s.data;
		end
	end

endmodule

// File: source/dvbs2_tx_top.sv
`timescale 1ns/1ps

module dvbs2_tx_top (
	input logic clk,
	input logic rst_n,
	input dvbs2_pkg::byte_t ts_data,
	input logic ts_valid,
	input logic ts_sync,
	output logic ts_ready,
	output logic sym_valid,
	input logic sym_ready,
	output dvbs2_pkg::sample_t sym_re,
	output dvbs2_pkg::sample_t sym_im
);

	// crc-stamped bytes
	byte_stream_if crc_s ();

	// scrambled bytes
	byte_stream_if scr_s ();

	ts_crc_inserter ts_crc_inserter0 (
		.clk(clk),
		.rst_n(rst_n),
		.ts_data(ts_data),
		.ts_valid(ts_valid),
		.ts_sync(ts_sync),
		.ts_ready(ts_ready),
		.out_s(crc_s.src)
	);

	bb_scrambler bb_scrambler0 (
		.clk(clk),
		.rst_n(rst_n),
		.in_s(crc_s.snk),
		.out_s(scr_s.src)
	);

	qpsk_mapper qpsk_mapper0 (
		.clk(clk),
		.rst_n(rst_n),
		.in_s(scr_s.snk),
		.sym_ready(sym_ready),
		.sym_valid(sym_valid),
		.sym_re(sym_re),
		.sym_im(sym_im)
	);

endmodule

// File: verif/tb_dvbs2_model.svh
`ifndef TB_DVBS2_MODEL_SVH
`define TB_DVBS2_MODEL_SVH

// model state, stepped once per accepted input byte
dvbs2_pkg::align_state_t m_state;
int m_pos;
int m_frm;
dvbs2_pkg::crc_t m_crc;
// stage 1 at index 1
logic [1:15] m_prbs;

dvbs2_pkg::sample_t exp_re_q[$];
dvbs2_pkg::sample_t exp_im_q[$];

// crc-8, msb first, x^8+x^7+x^6+x^4+x^2+1
function automatic dvbs2_pkg::crc_t crc8_update(input dvbs2_pkg::crc_t crc,
		input dvbs2_pkg::byte_t d);
	dvbs2_pkg::crc_t c;
	c = crc;
	for (int i = 7; i >= 0; i--) begin
		if (c[7] ^ d[i]) begin
			c = (c << 1) ^ `DVB_CRC_POLY;
		end else begin
			c = c << 1;
		end
	end
	return c;
endfunction

function automatic dvbs2_pkg::sample_t qpsk_level(input logic b);
	dvbs2_pkg::sample_t amp;
	amp = `DVB_QPSK_AMP;
	return b ? -amp : amp;
endfunction

task automatic model_reset();
	m_state = dvbs2_pkg::HUNT;
	m_pos = 0;
	m_frm = 0;
	m_crc = '0;
	m_prbs = `DVB_PRBS_SEED;
endtask

// queues the four symbols that one input byte should produce
task automatic model_push(input dvbs2_pkg::byte_t b, input logic sync);
	dvbs2_pkg::byte_t ob;
	dvbs2_pkg::byte_t sb;
	logic fs;
	logic pb;
	if (sync) begin
		m_state = dvbs2_pkg::IN_PACKET;
		m_pos = 0;
	end
	// bytes while hunting are dropped
	if (m_state == dvbs2_pkg::IN_PACKET) begin
		fs = 1'b0;
		if (m_pos == 0) begin
			ob = m_crc;
			m_crc = '0;
			fs = (m_frm == 0);
			m_frm = (m_frm + 1) % `DVB_FRAME_PKTS;
		end else begin
			ob = b;
			m_crc = crc8_update(m_crc, b);
		end
		m_pos = (m_pos + 1) % `DVB_PKT_BYTES;
		if (fs) begin
			m_prbs = `DVB_PRBS_SEED;
		end
		// 1 + x^14 + x^15
		for (int i = 7; i >= 0; i--) begin
			pb = m_prbs[14] ^ m_prbs[15];
			sb[i] = ob[i] ^ pb;
			m_prbs = {pb, m_prbs[1:14]};
		end
		for (int k = 0; k < 4; k++) begin
			exp_re_q.push_back(qpsk_level(sb[7 - 2 * k]));
			exp_im_q.push_back(qpsk_level(sb[6 - 2 * k]));
		end
	end
endtask

task automatic check_sample(input string name, input dvbs2_pkg::sample_t expected,
		input dvbs2_pkg::sample_t actual);
	if (actual !== expected) begin
		fail_run($sformatf("Error at time %0t: %s expected %h got %h",
			$time, name, expected, actual));
	end
endtask

task automatic check_count(input string name, input int expected, input int actual);
	if (actual != expected) begin
		fail_run($sformatf("Error at time %0t: %s expected %0d got %0d",
			$time, name, expected, actual));
	end
endtask

`endif

// File: verif/tb_dvbs2_tx.sv
`timescale 1ns/1ps
`include "dvbs2_defs.svh"

module tb_dvbs2_tx;

	localparam int TIMEOUT_CYCLES = 2000;
	localparam int PKT_BYTES = `DVB_PKT_BYTES;
	localparam int FRAME_SYMS = 4 * `DVB_PKT_BYTES * `DVB_FRAME_PKTS;

	logic clk;
	logic rst_n;
	dvbs2_pkg::byte_t ts_data;
	logic ts_valid;
	logic ts_sync;
	logic ts_ready;
	logic sym_valid;
	logic sym_ready;
	dvbs2_pkg::sample_t sym_re;
	dvbs2_pkg::sample_t sym_im;

	logic [31:0] stim_lfsr;
	logic [31:0] bp_lfsr;
	logic bp_on;
	logic gaps_on;
	int acc_bytes;
	int sym_count;
	int stall_cnt;
	dvbs2_pkg::sample_t got_re_q[$];
	dvbs2_pkg::sample_t got_im_q[$];
	// model values in output order
	dvbs2_pkg::sample_t ref_re_q[$];
	dvbs2_pkg::sample_t ref_im_q[$];
	dvbs2_pkg::sample_t e_re;
	dvbs2_pkg::sample_t e_im;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	`include "tb_dvbs2_model.svh"

	dvbs2_tx_top dut0 (
		.clk(clk),
		.rst_n(rst_n),
		.ts_data(ts_data),
		.ts_valid(ts_valid),
		.ts_sync(ts_sync),
		.ts_ready(ts_ready),
		.sym_valid(sym_valid),
		.sym_ready(sym_ready),
		.sym_re(sym_re),
		.sym_im(sym_im)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// galois form with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] st);
		return st[0] ? ((st >> 1) ^ 32'h8020_0003) : (st >> 1);
	endfunction

	function automatic logic [7:0] lfsr_bits(inout logic [31:0] st, input int n);
		logic [7:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[6:0], st[0]};
			st = lfsr_step(st);
		end
		return r;
	endfunction

	function automatic dvbs2_pkg::byte_t pattern_byte(input int pkt, input int pos);
		return dvbs2_pkg::byte_t'((pos * 13 + pkt * 71) ^ 165);
	endfunction

	// sink back-pressure with ready about three cycles in four
	initial begin
		sym_ready = 1'b1;
		bp_lfsr = 32'h90fa;
		forever begin
			@(posedge clk);
			if (bp_on) begin
				sym_ready <= (lfsr_bits(bp_lfsr, 2) != 8'd0);
			end else begin
				sym_ready <= 1'b1;
			end
		end
	end

	// sampled mid-cycle before the transfer edge
	initial begin
		sym_count = 0;
		stall_cnt = 0;
		forever begin
			@(negedge clk);
			if (rst_n && sym_valid && sym_ready) begin
				if (exp_re_q.size() == 0) begin
					fail_run("a symbol came out when none was expected");
				end else begin
					e_re = exp_re_q.pop_front();
					e_im = exp_im_q.pop_front();
					check_sample("sym_re", e_re, sym_re);
					check_sample("sym_im", e_im, sym_im);
					got_re_q.push_back(sym_re);
					got_im_q.push_back(sym_im);
					ref_re_q.push_back(e_re);
					ref_im_q.push_back(e_im);
					sym_count++;
				end
			end
			if (sym_valid && !sym_ready && !ts_ready) begin
				stall_cnt++;
			end
		end
	end

	task automatic drive_byte(input dvbs2_pkg::byte_t b, input logic sync);
		int waited;
		if (gaps_on && lfsr_bits(stim_lfsr, 2) == 8'd0) begin
			ts_valid <= 1'b0;
			ts_sync <= 1'b0;
			@(posedge clk);
		end
		ts_data <= b;
		ts_sync <= sync;
		ts_valid <= 1'b1;
		waited = 0;
		@(negedge clk);
		while (!ts_ready) begin
			waited++;
			if (waited > TIMEOUT_CYCLES) begin
				fail_run("ts_ready stayed low too long, input side is stuck");
			end
			@(negedge clk);
		end
		model_push(b, sync);
		acc_bytes++;
		@(posedge clk);
	endtask

	// pat below zero gives a random payload
	task automatic send_packet(input int len, input int pat);
		dvbs2_pkg::byte_t b;
		drive_byte(`DVB_SYNC_BYTE, 1'b1);
		for (int i = 1; i < len; i++) begin
			if (pat < 0) begin
				b = lfsr_bits(stim_lfsr, 8);
			end else begin
				b = pattern_byte(pat, i);
			end
			drive_byte(b, 1'b0);
		end
	endtask

	task automatic go_idle();
		ts_valid <= 1'b0;
		ts_sync <= 1'b0;
	endtask

	task automatic wait_drain();
		int waited;
		go_idle();
		waited = 0;
		while (exp_re_q.size() != 0) begin
			waited++;
			if (waited > TIMEOUT_CYCLES) begin
				fail_run("output did not drain, expected symbols never came out");
			end
			@(posedge clk);
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		rst_n <= 1'b0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		model_reset();
	endtask

	initial begin
		int sym_base;
		int acc_base;
		int stall_base;
		rst_n = 1'b0;
		ts_data = '0;
		ts_valid = 1'b0;
		ts_sync = 1'b0;
		stim_lfsr = 32'h90fa;
		bp_on = 1'b0;
		gaps_on = 1'b0;
		acc_bytes = 0;
		model_reset();
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		if (sym_valid) begin
			fail_run("sym_valid is high right after reset");
		end
		if (!ts_ready) begin
			fail_run("ts_ready is low right after reset");
		end
		@(posedge clk);

		// clean aligned stream
		acc_base = acc_bytes;
		sym_base = sym_count;
		for (int p = 0; p < 6; p++) begin
			send_packet(PKT_BYTES, -1);
		end
		wait_drain();
		check_count("sym_count", 4 * (acc_bytes - acc_base), sym_count - sym_base);

		// two frames with the same payloads
		apply_reset();
		sym_base = sym_count;
		for (int p = 0; p < 2 * `DVB_FRAME_PKTS; p++) begin
			send_packet(PKT_BYTES, p % `DVB_FRAME_PKTS);
		end
		wait_drain();
		check_count("sym_count", 2 * FRAME_SYMS, sym_count - sym_base);
		// first four symbols carry the frame's crc byte
		for (int i = 4; i < FRAME_SYMS; i++) begin
			check_sample("sym_re", ref_re_q[sym_base + i],
				got_re_q[sym_base + FRAME_SYMS + i]);
			check_sample("sym_im", ref_im_q[sym_base + i],
				got_im_q[sym_base + FRAME_SYMS + i]);
		end

		// junk before the first sync and then a sync mid-packet
		apply_reset();
		sym_base = sym_count;
		for (int i = 0; i < 25; i++) begin
			drive_byte(lfsr_bits(stim_lfsr, 8), 1'b0);
		end
		go_idle();
		repeat (10) @(posedge clk);
		check_count("sym_count", sym_base, sym_count);
		send_packet(100, -1);
		for (int p = 0; p < 3; p++) begin
			send_packet(PKT_BYTES, -1);
		end
		wait_drain();
		check_count("sym_count", 4 * (100 + 3 * PKT_BYTES), sym_count - sym_base);

		// random input gaps and output stalls
		apply_reset();
		sym_base = sym_count;
		acc_base = acc_bytes;
		stall_base = stall_cnt;
		gaps_on = 1'b1;
		bp_on <= 1'b1;
		for (int p = 0; p < 6; p++) begin
			send_packet(PKT_BYTES, -1);
		end
		wait_drain();
		gaps_on = 1'b0;
		bp_on <= 1'b0;
		check_count("sym_count", 4 * (acc_bytes - acc_base), sym_count - sym_base);
		if (stall_cnt == stall_base) begin
			fail_run("ts_ready never fell while the symbol output was stalled");
		end

		if (exp_re_q.size() == 0) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			fail_run("expected symbols remain that never came out");
		end
	end

endmodule

// File: filelist.f
+incdir+source
+incdir+verif
source/dvbs2_pkg.sv
source/byte_stream_if.sv
source/ts_crc_inserter.sv
source/bb_scrambler.sv
source/qpsk_mapper.sv
source/dvbs2_tx_top.sv
verif/tb_dvbs2_tx.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_dvbs2_tx
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --timescale 1ns/1ps -j 0
PASS_MSG ?= TEST RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
